//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_id_subsystem
FILELIST  := tb.f
LOG       := sim.log
BIN       := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard *.sv) id_input.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- core_pkg.sv
/*
  shared types for the RV64I decode stage
  one-hot selectors keep bit 0 as the first listed operation
  wb_sel is packed as {csr, mem, exe}
*/
package core_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  typedef logic [11:0] alu_op_t;
  typedef logic [7:0]  bj_op_t;
  typedef logic [6:0]  load_op_t;
  typedef logic [3:0]  store_op_t;
  typedef logic [2:0]  wb_sel_t;

  // alu selector bit positions
  localparam int alu_add  = 0;
  localparam int alu_sub  = 1;
  localparam int alu_slt  = 2;
  localparam int alu_sltu = 3;
  localparam int alu_xor  = 4;
  localparam int alu_or   = 5;
  localparam int alu_and  = 6;
  localparam int alu_sll  = 7;
  localparam int alu_srl  = 8;
  localparam int alu_sra  = 9;
  localparam int alu_andn = 10;
  localparam int alu_wri  = 11;

  // machine CSRs held by csr_file
  localparam csr_addr_t csr_mstatus  = 12'h300;
  localparam csr_addr_t csr_mtvec    = 12'h305;
  localparam csr_addr_t csr_mscratch = 12'h340;
  localparam csr_addr_t csr_mepc     = 12'h341;
  localparam csr_addr_t csr_mcause   = 12'h342;

  typedef struct packed {
    logic ecall;
    logic ebreak;
    logic mret;
    logic illegal;
  } excp_t;

  // decoder output, consumed by id_stage in the same cycle
  typedef struct packed {
    logic      is_load, is_fence, is_arith_i, is_arith_iw;
    logic      is_auipc, is_store, is_arith_r, is_arith_rw;
    logic      is_lui, is_branch, is_jalr, is_jal;
    logic      is_csr_reg, is_csr_imm;
    alu_op_t   alu_op;
    bj_op_t    bj_op;
    load_op_t  load_op;
    store_op_t store_op;
    reg_idx_t  rd, rs1, rs2;
    xlen_t     imm_i, imm_s, imm_b, imm_u, imm_j;
    xlen_t     zimm;
    excp_t     excp;
  } dec_t;

  // id -> ex pipeline register
  typedef struct packed {
    xlen_t     pc;
    inst_t     inst;
    reg_idx_t  rs1_addr, rs2_addr;
    xlen_t     op1, op2;
    logic      is_word;
    alu_op_t   alu_op;
    bj_op_t    bj_op;
    xlen_t     jmp_imm;
    xlen_t     rs2_data;
    load_op_t  load_op;
    store_op_t store_op;
    logic      mem_rd_ena, mem_wr_ena;
    wb_sel_t   wb_sel;
    logic      rd_ena;
    reg_idx_t  rd_addr;
    logic      csr_wr_ena;
    csr_addr_t csr_wr_addr;
    excp_t     excp;
  } id_ex_t;

endpackage

//--- csr_file.sv
/*
  mstatus, mtvec, mscratch, mepc and mcause only
  writes to other addresses are ignored and reads of them return zero
  no write bypass on the read port
*/
`timescale 1ns/1ps

module csr_file (
  input  logic                clk,
  input  logic                rst,
  input  logic                rd_ena,
  input  core_pkg::csr_addr_t rd_addr,
  output core_pkg::xlen_t     rd_data,
  input  logic                wr_ena,
  input  core_pkg::csr_addr_t wr_addr,
  input  core_pkg::xlen_t     wr_data
);
  import core_pkg::*;

  xlen_t mstatus, mtvec, mscratch, mepc, mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus  <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else if (wr_ena) begin
      case (wr_addr)
        csr_mstatus:  mstatus  <= wr_data;
        csr_mtvec:    mtvec    <= wr_data;
        csr_mscratch: mscratch <= wr_data;
        csr_mepc:     mepc     <= wr_data;
        csr_mcause:   mcause   <= wr_data;
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_data = '0;
    if (rd_ena) begin
      case (rd_addr)
        csr_mstatus:  rd_data = mstatus;
        csr_mtvec:    rd_data = mtvec;
        csr_mscratch: rd_data = mscratch;
        csr_mepc:     rd_data = mepc;
        csr_mcause:   rd_data = mcause;
        default:      rd_data = '0;
      endcase
    end
  end

endmodule

//--- id_decoder.sv
/*
  purely combinational RV64I decoder, no M/A/C extensions
  any encoding outside the supported set raises excp.illegal
  and leaves every class flag low
*/
`timescale 1ns/1ps

module id_decoder (
  input  core_pkg::inst_t inst,
  output core_pkg::dec_t  dec
);
  import core_pkg::*;

  wire [6:0] opcode = inst[6:0];
  wire [2:0] func3  = inst[14:12];
  wire [5:0] func6  = inst[31:26];
  wire [6:0] func7  = inst[31:25];
  wire [11:0] imm12 = inst[31:20];

  wire f3_0 = (func3 == 3'd0);
  wire f3_1 = (func3 == 3'd1);
  wire f3_2 = (func3 == 3'd2);
  wire f3_3 = (func3 == 3'd3);
  wire f3_4 = (func3 == 3'd4);
  wire f3_5 = (func3 == 3'd5);
  wire f3_6 = (func3 == 3'd6);
  wire f3_7 = (func3 == 3'd7);

  wire f6_00 = (func6 == 6'h00);
  wire f6_10 = (func6 == 6'h10);
  wire f7_00 = (func7 == 7'h00);
  wire f7_20 = (func7 == 7'h20);

  // major opcode groups
  wire op_load  = (opcode == 7'h03);
  wire op_fence = (opcode == 7'h0f);
  wire op_imm   = (opcode == 7'h13);
  wire op_auipc = (opcode == 7'h17);
  wire op_immw  = (opcode == 7'h1b);
  wire op_store = (opcode == 7'h23);
  wire op_reg   = (opcode == 7'h33);
  wire op_lui   = (opcode == 7'h37);
  wire op_regw  = (opcode == 7'h3b);
  wire op_br    = (opcode == 7'h63);
  wire op_jalr  = (opcode == 7'h67);
  wire op_jal   = (opcode == 7'h6f);
  wire op_sys   = (opcode == 7'h73);

  wire lb = op_load & f3_0, lh = op_load & f3_1, lw = op_load & f3_2;
  wire ld = op_load & f3_3, lbu = op_load & f3_4, lhu = op_load & f3_5;
  wire lwu = op_load & f3_6;

  wire fence = op_fence & f3_0, fence_i = op_fence & f3_1;

  wire addi = op_imm & f3_0, slti = op_imm & f3_2, sltiu = op_imm & f3_3;
  wire xori = op_imm & f3_4, ori = op_imm & f3_6, andi = op_imm & f3_7;
  // RV64 shifts carry a 6-bit shamt
  wire slli = op_imm & f3_1 & f6_00;
  wire srli = op_imm & f3_5 & f6_00, srai = op_imm & f3_5 & f6_10;

  wire addiw = op_immw & f3_0, slliw = op_immw & f3_1 & f7_00;
  wire srliw = op_immw & f3_5 & f7_00, sraiw = op_immw & f3_5 & f7_20;

  wire sb = op_store & f3_0, sh = op_store & f3_1;
  wire sw = op_store & f3_2, sd = op_store & f3_3;

  wire add_r = op_reg & f3_0 & f7_00, sub_r = op_reg & f3_0 & f7_20;
  wire sll_r = op_reg & f3_1 & f7_00, slt_r = op_reg & f3_2 & f7_00;
  wire sltu_r = op_reg & f3_3 & f7_00, xor_r = op_reg & f3_4 & f7_00;
  wire srl_r = op_reg & f3_5 & f7_00, sra_r = op_reg & f3_5 & f7_20;
  wire or_r = op_reg & f3_6 & f7_00, and_r = op_reg & f3_7 & f7_00;

  wire addw = op_regw & f3_0 & f7_00, subw = op_regw & f3_0 & f7_20;
  wire sllw = op_regw & f3_1 & f7_00;
  wire srlw = op_regw & f3_5 & f7_00, sraw = op_regw & f3_5 & f7_20;

  wire beq = op_br & f3_0, bne = op_br & f3_1, blt = op_br & f3_4;
  wire bge = op_br & f3_5, bltu = op_br & f3_6, bgeu = op_br & f3_7;

  wire jalr = op_jalr & f3_0, jal = op_jal;

  // privileged forms share func3 == 0 and differ only in imm12
  wire ecall = op_sys & f3_0 & (imm12 == 12'h000);
  wire ebreak = op_sys & f3_0 & (imm12 == 12'h001);
  wire mret = op_sys & f3_0 & (imm12 == 12'h302);

  wire csrrw = op_sys & f3_1, csrrs = op_sys & f3_2, csrrc = op_sys & f3_3;
  wire csrrwi = op_sys & f3_5, csrrsi = op_sys & f3_6, csrrci = op_sys & f3_7;

  wire load_vld = lb | lh | lw | ld | lbu | lhu | lwu;
  wire fence_vld = fence | fence_i;
  wire arith_i_vld = addi | slti | sltiu | xori | ori | andi | slli | srli | srai;
  wire arith_iw_vld = addiw | slliw | srliw | sraiw;
  wire store_vld = sb | sh | sw | sd;
  wire arith_r_vld = add_r | sub_r | sll_r | slt_r | sltu_r | xor_r | srl_r | sra_r
                   | or_r | and_r;
  wire arith_rw_vld = addw | subw | sllw | srlw | sraw;
  wire branch_vld = beq | bne | blt | bge | bltu | bgeu;
  wire csr_reg_vld = csrrw | csrrs | csrrc;
  wire csr_imm_vld = csrrwi | csrrsi | csrrci;

  wire inst_vld = load_vld | fence_vld | arith_i_vld | arith_iw_vld | op_auipc
                | store_vld | arith_r_vld | arith_rw_vld | op_lui | branch_vld
                | jalr | jal | csr_reg_vld | csr_imm_vld | ecall | ebreak | mret;

  always_comb begin
    dec = '0;
    dec.is_load     = load_vld;
    dec.is_fence    = fence_vld;
    dec.is_arith_i  = arith_i_vld;
    dec.is_arith_iw = arith_iw_vld;
    dec.is_auipc    = op_auipc;
    dec.is_store    = store_vld;
    dec.is_arith_r  = arith_r_vld;
    dec.is_arith_rw = arith_rw_vld;
    dec.is_lui      = op_lui;
    dec.is_branch   = branch_vld;
    dec.is_jalr     = jalr;
    dec.is_jal      = jal;
    dec.is_csr_reg  = csr_reg_vld;
    dec.is_csr_imm  = csr_imm_vld;

    // address math for loads, stores and links goes through add
    dec.alu_op[alu_add]  = add_r | addi | addw | addiw | op_auipc | op_lui
                         | load_vld | store_vld | jal | jalr;
    dec.alu_op[alu_sub]  = sub_r | subw | branch_vld;
    dec.alu_op[alu_slt]  = slt_r | slti | blt | bge;
    dec.alu_op[alu_sltu] = sltu_r | sltiu | bltu | bgeu;
    dec.alu_op[alu_xor]  = xor_r | xori | beq | bne;
    dec.alu_op[alu_or]   = or_r | ori | csrrs | csrrsi;
    dec.alu_op[alu_and]  = and_r | andi;
    dec.alu_op[alu_sll]  = sll_r | slli | sllw | slliw;
    dec.alu_op[alu_srl]  = srl_r | srli | srlw | srliw;
    dec.alu_op[alu_sra]  = sra_r | srai | sraw | sraiw;
    dec.alu_op[alu_andn] = csrrc | csrrci;
    dec.alu_op[alu_wri]  = csrrw | csrrwi;

    dec.bj_op    = {jal, jalr, bgeu, bltu, bge, blt, bne, beq};
    dec.load_op  = {lwu, lhu, lbu, ld, lw, lh, lb};
    dec.store_op = {sd, sw, sh, sb};

    dec.rd  = inst[11:7];
    dec.rs1 = inst[19:15];
    dec.rs2 = inst[24:20];

    dec.imm_i = {{52{inst[31]}}, inst[31:20]};
    dec.imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    dec.imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    dec.imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    dec.imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    dec.zimm  = {59'b0, inst[19:15]};

    dec.excp.ecall   = ecall;
    dec.excp.ebreak  = ebreak;
    dec.excp.mret    = mret;
    dec.excp.illegal = ~inst_vld;
  end

endmodule

//--- id_input.txt
# W reg data | C csr data | I pc inst op1 op2 alu bj jmp rs2_data
#   load store mem_rd mem_wr wb_sel rd csr_wr_ena csr_wr_addr excp (all hex)
W 01 80000001fffffff0
W 02 5
W 03 123456789abcdef0
W 05 ffffffffffffffff
W 00 1111
C 300 1800
C 305 80000100
C 340 deadbeef00000000
C 341 80001000
C 342 b
C 7c0 5555
# register and immediate arithmetic
I 1000 00208233 80000001fffffff0 5 001 00 0 5 00 0 0 0 1 04 0 000 0
I 1004 40518333 123456789abcdef0 ffffffffffffffff 002 00 0
  ffffffffffffffff 00 0 0 0 1 06 0 000 0
I 1008 4020d3b3 80000001fffffff0 5 200 00 0 5 00 0 0 0 1 07 0 000 0
I 100c fff10413 5 ffffffffffffffff 001 00 0 0 00 0 0 0 1 08 0 000 0
I 1010 4041d493 123456789abcdef0 404 200 00 0 0 00 0 0 0 1 09 0 000 0
I 1014 0100851b fffffff0 10 001 00 0 0 00 0 0 0 1 0a 0 000 0
I 1018 405085bb fffffff0 ffffffff 002 00 0 ffffffffffffffff 00 0 0 0 1 0b 0 000 0
I 101c 0021963b 9abcdef0 5 080 00 0 5 00 0 0 0 1 0c 0 000 0
# lui, auipc, jumps and branches
I 1020 123456b7 0 12345000 001 00 0 0 00 0 0 0 1 0d 0 000 0
I 1024 80000737 0 ffffffff80000000 001 00 0 0 00 0 0 0 1 0e 0 000 0
I 1028 00001797 1028 1000 001 00 0 0 00 0 0 0 1 0f 0 000 0
I 102c 010000ef 102c 4 001 80 10 0 00 0 0 0 1 01 0 000 0
I 1030 ff8182e7 1030 4 001 40 fffffffffffffff8 0 00 0 0 0 1 05 0 000 0
I 1034 00208463 80000001fffffff0 5 012 01 8 5 00 0 0 0 0 00 0 000 0
I 1038 fe51e8e3 123456789abcdef0 ffffffffffffffff 00a 10 fffffffffffffff0
  ffffffffffffffff 00 0 0 0 0 00 0 000 0
# loads and stores
I 103c 00c12803 5 c 001 00 0 0 04 0 1 0 2 10 0 000 0
I 1040 fff1c883 123456789abcdef0 ffffffffffffffff 001 00 0 0 10 0 1 0 2 11 0 000 0
I 1044 0000b903 80000001fffffff0 0 001 00 0 0 08 0 1 0 2 12 0 000 0
I 1048 00313423 5 8 001 00 0 123456789abcdef0 00 8 0 1 0 00 0 000 0
I 104c fe508e23 80000001fffffff0 fffffffffffffffc 001 00 0
  ffffffffffffffff 00 1 0 1 0 00 0 000 0
# CSR instructions, the last one addresses a CSR outside the set
I 1050 340199f3 deadbeef00000000 123456789abcdef0 800 00 0 0 00 0 0 0 4 13 1 340 0
I 1054 30012a73 1800 5 020 00 0 0 00 0 0 0 4 14 1 300 0
I 1058 3412baf3 80001000 ffffffffffffffff 400 00 0 0 00 0 0 0 4 15 1 341 0
I 105c 3053db73 80000100 7 800 00 0 0 00 0 0 0 4 16 1 305 0
I 1060 342febf3 b 1f 020 00 0 0 00 0 0 0 4 17 1 342 0
I 1064 7c00fc73 0 1 400 00 0 0 00 0 0 0 4 18 1 7c0 0
# ecall, ebreak, mret, undefined, fence
I 1068 00000073 0 0 000 00 0 0 00 0 0 0 0 00 0 000 8
I 106c 00100073 0 0 000 00 0 0 00 0 0 0 0 00 0 000 4
I 1070 30200073 0 0 000 00 0 0 00 0 0 0 0 00 0 000 2
I 1074 ffffffff 0 0 000 00 0 0 00 0 0 0 0 00 0 000 1
I 1078 0ff0000f 0 ff 000 00 0 0 00 0 0 0 1 00 0 000 0

//--- id_stage.sv
/*
  single-slot decode stage with valid/allowin handshake, never stalls itself
  register and CSR reads are issued for the instruction at the input,
  results are captured only on an upstream transfer
*/
`timescale 1ns/1ps

module id_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                if_id_valid,
  output logic                id_allowin,
  input  logic                ex_allowin,
  output logic                id_ex_valid,
  input  core_pkg::xlen_t     pc,
  input  core_pkg::inst_t     inst,
  input  core_pkg::dec_t      dec,
  output logic                rs1_ena,
  output core_pkg::reg_idx_t  rs1_addr,
  output logic                rs2_ena,
  output core_pkg::reg_idx_t  rs2_addr,
  output logic                csr_rd_ena,
  output core_pkg::csr_addr_t csr_rd_addr,
  input  core_pkg::xlen_t     r_data1,
  input  core_pkg::xlen_t     r_data2,
  input  core_pkg::xlen_t     csr_data,
  output core_pkg::id_ex_t    id_ex
);
  import core_pkg::*;

  localparam xlen_t lo32_mask = 64'h0000_0000_ffff_ffff;

  logic   valid;
  logic   ready_go;
  logic   is_word;
  logic   csr_any;
  logic   rd_ena;
  id_ex_t nxt;

  // handshake
  assign ready_go    = 1'b1;
  assign id_allowin  = !valid || (ready_go && ex_allowin);
  assign id_ex_valid = valid && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (id_allowin) begin
      valid <= if_id_valid;
    end
  end

  assign is_word = dec.is_arith_iw | dec.is_arith_rw;
  assign csr_any = dec.is_csr_reg | dec.is_csr_imm;
  assign rd_ena  = dec.is_load | dec.is_fence | dec.is_arith_i | dec.is_arith_iw
                 | dec.is_auipc | dec.is_arith_r | dec.is_arith_rw | dec.is_lui
                 | dec.is_jalr | dec.is_jal | csr_any;

  // read ports, address forced to zero when unused
  assign rs1_ena = dec.is_load | dec.is_fence | dec.is_arith_i | dec.is_arith_iw
                 | dec.is_store | dec.is_arith_r | dec.is_arith_rw | dec.is_branch
                 | dec.is_jalr | dec.is_csr_reg;
  assign rs2_ena = dec.is_arith_r | dec.is_arith_rw | dec.is_store | dec.is_branch;
  assign rs1_addr    = rs1_ena ? dec.rs1 : reg_idx_t'(0);
  assign rs2_addr    = rs2_ena ? dec.rs2 : reg_idx_t'(0);
  assign csr_rd_ena  = csr_any;
  assign csr_rd_addr = csr_any ? csr_addr_t'(inst[31:20]) : csr_addr_t'(0);

  always_comb begin
    nxt          = '0;
    nxt.pc       = pc;
    nxt.inst     = inst;
    nxt.rs1_addr = rs1_addr;
    nxt.rs2_addr = rs2_addr;
    nxt.is_word  = is_word;
    nxt.alu_op   = dec.alu_op;
    nxt.bj_op    = dec.bj_op;

    // op1
    if (dec.is_auipc || dec.is_jal || dec.is_jalr) begin
      nxt.op1 = pc;
    end else if (dec.is_lui) begin
      nxt.op1 = '0;
    end else if (csr_any) begin
      nxt.op1 = csr_data;
    end else if (is_word) begin
      nxt.op1 = r_data1 & lo32_mask;
    end else begin
      nxt.op1 = r_data1;
    end

    // op2, link value of 4 for jumps
    if (dec.is_jal || dec.is_jalr) begin
      nxt.op2 = 64'd4;
    end else if (dec.is_lui || dec.is_auipc) begin
      nxt.op2 = dec.imm_u;
    end else if (dec.is_store) begin
      nxt.op2 = dec.imm_s;
    end else if (dec.is_load || dec.is_fence || dec.is_arith_i || dec.is_arith_iw) begin
      nxt.op2 = dec.imm_i;
    end else if (dec.is_csr_imm) begin
      nxt.op2 = dec.zimm;
    end else if (dec.is_csr_reg) begin
      nxt.op2 = r_data1;
    end else if (dec.is_arith_rw) begin
      nxt.op2 = r_data2 & lo32_mask;
    end else begin
      nxt.op2 = r_data2;
    end

    if (dec.is_branch) begin
      nxt.jmp_imm = dec.imm_b;
    end else if (dec.is_jal) begin
      nxt.jmp_imm = dec.imm_j;
    end else if (dec.is_jalr) begin
      nxt.jmp_imm = dec.imm_i;
    end

    nxt.rs2_data    = r_data2;
    nxt.load_op     = dec.load_op;
    nxt.store_op    = dec.store_op;
    nxt.mem_rd_ena  = dec.is_load;
    nxt.mem_wr_ena  = dec.is_store;
    nxt.wb_sel      = {csr_any, dec.is_load, rd_ena & ~csr_any & ~dec.is_load};
    nxt.rd_ena      = rd_ena;
    nxt.rd_addr     = rd_ena ? dec.rd : reg_idx_t'(0);
    nxt.csr_wr_ena  = csr_any;
    nxt.csr_wr_addr = csr_rd_addr;
    nxt.excp        = dec.excp;
  end

  // payload held while stalled
  always_ff @(posedge clk) begin
    if (if_id_valid && id_allowin) begin
      id_ex <= nxt;
    end
  end

endmodule

//--- id_subsystem.sv
/*
  decode stage with its register and CSR files
  writeback enters only through the external write ports
*/
`timescale 1ns/1ps

module id_subsystem (
  input  logic                clk,
  input  logic                rst,
  input  logic                if_id_valid,
  output logic                id_allowin,
  input  core_pkg::xlen_t     pc,
  input  core_pkg::inst_t     inst,
  input  logic                ex_allowin,
  output logic                id_ex_valid,
  output core_pkg::id_ex_t    id_ex,
  input  logic                wb_wr_ena,
  input  core_pkg::reg_idx_t  wb_wr_addr,
  input  core_pkg::xlen_t     wb_wr_data,
  input  logic                csr_wr_ena_in,
  input  core_pkg::csr_addr_t csr_wr_addr_in,
  input  core_pkg::xlen_t     csr_wr_data
);
  import core_pkg::*;

  dec_t      dec;
  logic      rs1_ena, rs2_ena, csr_rd_ena;
  reg_idx_t  rs1_addr, rs2_addr;
  csr_addr_t csr_rd_addr;
  xlen_t     r_data1, r_data2, csr_data;

  id_decoder i_decoder (
    .inst (inst),
    .dec  (dec)
  );

  id_stage i_stage (
    .clk         (clk),
    .rst         (rst),
    .if_id_valid (if_id_valid),
    .id_allowin  (id_allowin),
    .ex_allowin  (ex_allowin),
    .id_ex_valid (id_ex_valid),
    .pc          (pc),
    .inst        (inst),
    .dec         (dec),
    .rs1_ena     (rs1_ena),
    .rs1_addr    (rs1_addr),
    .rs2_ena     (rs2_ena),
    .rs2_addr    (rs2_addr),
    .csr_rd_ena  (csr_rd_ena),
    .csr_rd_addr (csr_rd_addr),
    .r_data1     (r_data1),
    .r_data2     (r_data2),
    .csr_data    (csr_data),
    .id_ex       (id_ex)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_ena  (rs1_ena),
    .rs1_addr (rs1_addr),
    .r_data1  (r_data1),
    .rs2_ena  (rs2_ena),
    .rs2_addr (rs2_addr),
    .r_data2  (r_data2),
    .wr_ena   (wb_wr_ena),
    .wr_addr  (wb_wr_addr),
    .wr_data  (wb_wr_data)
  );

  csr_file i_csr_file (
    .clk     (clk),
    .rst     (rst),
    .rd_ena  (csr_rd_ena),
    .rd_addr (csr_rd_addr),
    .rd_data (csr_data),
    .wr_ena  (csr_wr_ena_in),
    .wr_addr (csr_wr_addr_in),
    .wr_data (csr_wr_data)
  );

endmodule

//--- id_subsystem_properties.sv
/*
  handshake and reset properties, bound into id_subsystem
  slot occupancy is seen through id_ex_valid since the stage never stalls itself
*/
`timescale 1ns/1ps

module id_subsystem_properties (
  input logic             clk,
  input logic             rst,
  input logic             if_id_valid,
  input logic             id_allowin,
  input logic             ex_allowin,
  input logic             id_ex_valid,
  input core_pkg::id_ex_t id_ex
);
  import core_pkg::*;

  // nothing leaves the stage right after reset
  a_reset_empty: assert property (@(posedge clk) rst |=> !id_ex_valid)
    else $error("id_ex_valid high after reset");

  // stalled bundle must not move
  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    (id_ex_valid && !ex_allowin) |=> (id_ex_valid && $stable(id_ex)))
    else $error("id_ex changed while stalled");

  // one cycle from upstream accept to downstream valid
  a_one_cycle: assert property (@(posedge clk) disable iff (rst)
    (if_id_valid && id_allowin) |=> id_ex_valid)
    else $error("accepted instruction not valid on id_ex one cycle later");

  a_empty_allows: assert property (@(posedge clk) disable iff (rst)
    !id_ex_valid |-> id_allowin)
    else $error("id_allowin low with an empty slot");

endmodule

bind id_subsystem id_subsystem_properties i_props (
  .clk         (clk),
  .rst         (rst),
  .if_id_valid (if_id_valid),
  .id_allowin  (id_allowin),
  .ex_allowin  (ex_allowin),
  .id_ex_valid (id_ex_valid),
  .id_ex       (id_ex)
);

//--- reg_file.sv
/*
  32 x 64-bit integer registers, x0 reads zero
  reads are combinational with no write bypass, so a read in the
  write cycle returns the old value
*/
`timescale 1ns/1ps

module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  logic               rs1_ena,
  input  core_pkg::reg_idx_t rs1_addr,
  output core_pkg::xlen_t    r_data1,
  input  logic               rs2_ena,
  input  core_pkg::reg_idx_t rs2_addr,
  output core_pkg::xlen_t    r_data2,
  input  logic               wr_ena,
  input  core_pkg::reg_idx_t wr_addr,
  input  core_pkg::xlen_t    wr_data
);
  import core_pkg::*;

  xlen_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && (wr_addr != reg_idx_t'(0))) begin
      // x0 stays hardwired to zero
      regs[wr_addr] <= wr_data;
    end
  end

  assign r_data1 = rs1_ena ? regs[rs1_addr] : xlen_t'(0);
  assign r_data2 = rs2_ena ? regs[rs2_addr] : xlen_t'(0);

endmodule

//--- tb.f
core_pkg.sv
id_decoder.sv
id_stage.sv
reg_file.sv
csr_file.sv
id_subsystem.sv
id_subsystem_properties.sv
tb_id_subsystem.sv

//--- tb_id_subsystem.sv
/*
  testbench for id_subsystem, stimulus and expected values come from id_input.txt
  the instruction list is sent once with ex_allowin high, then replayed
  with random valid gaps and random back-pressure
*/
`timescale 1ns/1ps

module tb_id_subsystem;
  import core_pkg::*;

  typedef struct packed {
    logic      is_csr;
    csr_addr_t addr;
    xlen_t     data;
  } pre_t;

  typedef struct packed {
    xlen_t     pc;
    inst_t     inst;
    xlen_t     op1, op2;
    alu_op_t   alu_op;
    bj_op_t    bj_op;
    xlen_t     jmp_imm;
    xlen_t     rs2_data;
    load_op_t  load_op;
    store_op_t store_op;
    logic      mem_rd_ena, mem_wr_ena;
    wb_sel_t   wb_sel;
    reg_idx_t  rd_addr;
    logic      csr_wr_ena;
    csr_addr_t csr_wr_addr;
    excp_t     excp;
  } exp_t;

  localparam int replay_passes = 3;

  logic      clk;
  logic      rst;
  logic      if_id_valid;
  logic      id_allowin;
  xlen_t     pc;
  inst_t     inst;
  logic      ex_allowin;
  logic      id_ex_valid;
  id_ex_t    id_ex;
  logic      wb_wr_ena;
  reg_idx_t  wb_wr_addr;
  xlen_t     wb_wr_data;
  logic      csr_wr_ena_in;
  csr_addr_t csr_wr_addr_in;
  xlen_t     csr_wr_data;

  integer seed;
  int     mismatches;
  int     other_errors;
  int     n_sent;
  int     n_recv;
  bit     loaded;
  pre_t   pres[$];
  exp_t   progs[$];
  exp_t   pending[$];

  id_subsystem i_dut (
    .clk            (clk),
    .rst            (rst),
    .if_id_valid    (if_id_valid),
    .id_allowin     (id_allowin),
    .pc             (pc),
    .inst           (inst),
    .ex_allowin     (ex_allowin),
    .id_ex_valid    (id_ex_valid),
    .id_ex          (id_ex),
    .wb_wr_ena      (wb_wr_ena),
    .wb_wr_addr     (wb_wr_addr),
    .wb_wr_data     (wb_wr_data),
    .csr_wr_ena_in  (csr_wr_ena_in),
    .csr_wr_addr_in (csr_wr_addr_in),
    .csr_wr_data    (csr_wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic load_records();
    integer         fd;
    integer         r;
    logic [7:0]     tag;
    logic [8*256-1:0] line;
    logic [63:0]    f [17];
    pre_t           p;
    exp_t           e;
    fd = $fopen("id_input.txt", "r");
    if (fd == 0) begin
      $display("could not open id_input.txt");
      other_errors++;
      return;
    end
    forever begin
      r = $fscanf(fd, "%s", tag);
      if (r != 1) break;
      if (tag == "#") begin
        r = $fgets(line, fd);
      end else if (tag == "W" || tag == "C") begin
        r = $fscanf(fd, "%h %h", f[0], f[1]);
        p.is_csr = (tag == "C");
        p.addr   = f[0][11:0];
        p.data   = f[1];
        pres.push_back(p);
      end else if (tag == "I") begin
        r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                    f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
        if (r != 17) begin
          $display("malformed instruction record in id_input.txt");
          other_errors++;
          break;
        end
        e.pc          = f[0];
        e.inst        = f[1][31:0];
        e.op1         = f[2];
        e.op2         = f[3];
        e.alu_op      = f[4][11:0];
        e.bj_op       = f[5][7:0];
        e.jmp_imm     = f[6];
        e.rs2_data    = f[7];
        e.load_op     = f[8][6:0];
        e.store_op    = f[9][3:0];
        e.mem_rd_ena  = f[10][0];
        e.mem_wr_ena  = f[11][0];
        e.wb_sel      = f[12][2:0];
        e.rd_addr     = f[13][4:0];
        e.csr_wr_ena  = f[14][0];
        e.csr_wr_addr = f[15][11:0];
        e.excp        = f[16][3:0];
        progs.push_back(e);
      end else begin
        $display("unknown record tag in id_input.txt");
        other_errors++;
        break;
      end
    end
    $fclose(fd);
  endtask

  task automatic apply_preloads();
    foreach (pres[i]) begin
      @(negedge clk);
      wb_wr_ena      = !pres[i].is_csr;
      wb_wr_addr     = pres[i].addr[4:0];
      wb_wr_data     = pres[i].data;
      csr_wr_ena_in  = pres[i].is_csr;
      csr_wr_addr_in = pres[i].addr;
      csr_wr_data    = pres[i].data;
    end
    @(negedge clk);
    wb_wr_ena     = 1'b0;
    csr_wr_ena_in = 1'b0;
  endtask

  // one instruction stays on the bus until it is accepted
  task automatic send_stream(input bit random_mode);
    int idx;
    bit presenting;
    idx = 0;
    presenting = 1'b0;
    while (idx < progs.size()) begin
      @(negedge clk);
      if (random_mode) begin
        ex_allowin = ($random(seed) & 3) != 0;
      end else begin
        ex_allowin = 1'b1;
      end
      if (!presenting) begin
        if (!random_mode || (($random(seed) & 3) != 0)) begin
          pc          = progs[idx].pc;
          inst        = progs[idx].inst;
          if_id_valid = 1'b1;
          presenting  = 1'b1;
        end else begin
          if_id_valid = 1'b0;
        end
      end
      #1;
      if (presenting && id_allowin) begin
        pending.push_back(progs[idx]);
        n_sent++;
        idx++;
        presenting = 1'b0;
      end
    end
  endtask

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp, input xlen_t at_pc);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s got %h expected %h (pc %h)",
               $time, name, got, exp, at_pc);
    end
  endtask

  task automatic score_transfer();
    exp_t        e;
    logic [6:0]  opc;
    logic        legal;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        word_op;
    logic [63:0] exp_rs1;
    logic [63:0] exp_rs2;
    if (pending.size() == 0) begin
      other_errors++;
      $display("output transfer at %0t ns with no instruction pending", $time);
      return;
    end
    e = pending.pop_front();
    n_recv++;

    // source registers by instruction format, unused sources read as x0
    opc      = e.inst[6:0];
    legal    = !e.excp.illegal;
    uses_rs2 = legal && (opc inside {7'h23, 7'h33, 7'h3b, 7'h63});
    uses_rs1 = legal && (uses_rs2 || (opc inside {7'h03, 7'h0f, 7'h13, 7'h1b, 7'h67})
               || ((opc == 7'h73) && (e.inst[14:12] inside {3'd1, 3'd2, 3'd3})));
    word_op  = legal && (opc inside {7'h1b, 7'h3b});
    exp_rs1  = uses_rs1 ? 64'(e.inst[19:15]) : 64'd0;
    exp_rs2  = uses_rs2 ? 64'(e.inst[24:20]) : 64'd0;

    check_field("pc", id_ex.pc, e.pc, e.pc);
    check_field("inst", 64'(id_ex.inst), 64'(e.inst), e.pc);
    check_field("rs1_addr", 64'(id_ex.rs1_addr), exp_rs1, e.pc);
    check_field("rs2_addr", 64'(id_ex.rs2_addr), exp_rs2, e.pc);
    check_field("op1", id_ex.op1, e.op1, e.pc);
    check_field("op2", id_ex.op2, e.op2, e.pc);
    check_field("is_word", 64'(id_ex.is_word), 64'(word_op), e.pc);
    check_field("alu_op", 64'(id_ex.alu_op), 64'(e.alu_op), e.pc);
    check_field("bj_op", 64'(id_ex.bj_op), 64'(e.bj_op), e.pc);
    check_field("jmp_imm", id_ex.jmp_imm, e.jmp_imm, e.pc);
    check_field("rs2_data", id_ex.rs2_data, e.rs2_data, e.pc);
    check_field("load_op", 64'(id_ex.load_op), 64'(e.load_op), e.pc);
    check_field("store_op", 64'(id_ex.store_op), 64'(e.store_op), e.pc);
    check_field("mem_rd_ena", 64'(id_ex.mem_rd_ena), 64'(e.mem_rd_ena), e.pc);
    check_field("mem_wr_ena", 64'(id_ex.mem_wr_ena), 64'(e.mem_wr_ena), e.pc);
    check_field("wb_sel", 64'(id_ex.wb_sel), 64'(e.wb_sel), e.pc);
    // any writeback source means rd is written
    check_field("rd_ena", 64'(id_ex.rd_ena), 64'(e.wb_sel != 3'd0), e.pc);
    check_field("rd_addr", 64'(id_ex.rd_addr), 64'(e.rd_addr), e.pc);
    check_field("csr_wr_ena", 64'(id_ex.csr_wr_ena), 64'(e.csr_wr_ena), e.pc);
    check_field("csr_wr_addr", 64'(id_ex.csr_wr_addr), 64'(e.csr_wr_addr), e.pc);
    check_field("excp", 64'(id_ex.excp), 64'(e.excp), e.pc);
  endtask

  // sample in the low phase, well away from both edges
  initial begin
    forever begin
      @(negedge clk);
      #1;
      if (!rst && id_ex_valid && ex_allowin) begin
        score_transfer();
      end
    end
  end

  initial begin
    int limit;
    wait (loaded);
    limit = (pres.size() + progs.size() * (replay_passes + 1)) * 20 + 40;
    repeat (limit) @(posedge clk);
    $display("timeout: outputs stopped arriving, %0d of %0d received", n_recv, n_sent);
    $display("Test failures found");
    $finish;
  end

  initial begin
    seed           = 42115;
    mismatches     = 0;
    other_errors   = 0;
    n_sent         = 0;
    n_recv         = 0;
    rst            = 1'b1;
    if_id_valid    = 1'b0;
    pc             = '0;
    inst           = '0;
    ex_allowin     = 1'b1;
    wb_wr_ena      = 1'b0;
    wb_wr_addr     = '0;
    wb_wr_data     = '0;
    csr_wr_ena_in  = 1'b0;
    csr_wr_addr_in = '0;
    csr_wr_data    = '0;
    load_records();
    if (progs.size() == 0) begin
      $display("no instructions loaded from id_input.txt");
      other_errors++;
    end
    loaded = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    apply_preloads();
    for (int pass = 0; pass <= replay_passes; pass++) begin
      send_stream(pass != 0);
    end
    @(negedge clk);
    if_id_valid = 1'b0;
    ex_allowin  = 1'b1;
    while (n_recv < n_sent) @(negedge clk);
    repeat (2) @(negedge clk);
    $display("errors: %0d mismatches, %0d other, %0d of %0d instructions received",
             mismatches, other_errors, n_recv, n_sent);
    if (mismatches == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
